/* lpif_pkg.sv */
// Widths, field layout and PHY bit map for the slave link adapter
// One PHY channel only, and the 141-bit flit layout is fixed
// Marker width and persistence are fixed here for the whole design
package lpif_pkg;

  ////////////////////////////////////////////////////////////
  // Flit fields, MSB first
  localparam int STATE_W       = 4;
  localparam int PROTID_W      = 2;
  localparam int DATA_W        = 128;
  localparam int CRC_W         = 4;
  // state, protid, data, dvalid, crc, crc_valid, valid
  localparam int FLIT_W        = STATE_W + PROTID_W + DATA_W + 1 + CRC_W + 1 + 1;
  // Data field starts above dvalid, crc, crc_valid and valid
  localparam int FLIT_DATA_LSB = 1 + CRC_W + 1 + 1;
  // Gen1 carries only the low half of the data field
  localparam int GEN1_DATA_W   = 64;

  ////////////////////////////////////////////////////////////
  // PHY word layout
  localparam int PHY_W         = 160;
  localparam int PHY_STB_BIT   = 1;
  localparam int PHY_MRK0_BIT  = 79;
  localparam int PHY_MRK1_BIT  = 159;
  // Flit bits 0..76 sit on PHY 2..78
  localparam int FLIT_LO_BASE  = 2;
  localparam int FLIT_LO_W     = 77;
  // Flit bits 77..140 sit on PHY 80..143
  localparam int FLIT_HI_BASE  = 80;
  localparam int FLIT_HI_W     = FLIT_W - FLIT_LO_W;

  ////////////////////////////////////////////////////////////
  // Auto-sync settings
  localparam int DELAY_W           = 16;
  localparam int MARKER_WIDTH      = 2;
  localparam bit PERSISTENT_MARKER = 1'b1;
  localparam bit PERSISTENT_STROBE = 1'b1;
  // Shorter strobe periods are stretched to this
  localparam int MIN_STB_PERIOD    = 2;

  typedef logic [FLIT_W-1:0]       flit_t;
  typedef logic [PHY_W-1:0]        phy_word_t;
  typedef logic [DATA_W-1:0]       user_data_t;
  typedef logic [DELAY_W-1:0]      delay_t;
  // One marker per 80-bit half of the PHY word
  typedef logic [MARKER_WIDTH-1:0] marker_t;

  // Online sequencer, tx comes up before rx
  typedef enum logic [2:0] {
    OFFLINE,
    TX_WAIT,
    TX_UP,
    RX_WAIT,
    LINK_UP
  } sync_state_t;

endpackage

/* lpif_sync_if.sv */
// Delayed online flags and auto userbits from auto-sync to the PHY concat
// Plain wires, no clock; all four are driven by one source
`timescale 1ns/1ps

interface lpif_sync_if import lpif_pkg::*; ();

  // Held-off online flags
  logic    tx_online_delay;
  logic    rx_online_delay;

  // Gated marker bits, one per PHY half
  marker_t mrk_userbit;
  // Periodic strobe, user strobe ORed in
  logic    stb_userbit;

  // Auto-sync side
  modport src (
    output tx_online_delay,
    output rx_online_delay,
    output mrk_userbit,
    output stb_userbit
  );

  // Consumer side, concat and debug
  modport dst (
    input tx_online_delay,
    input rx_online_delay,
    input mrk_userbit,
    input stb_userbit
  );

endinterface

/* ll_auto_sync.sv */
// Holds back tx and rx online by delay_x and delay_y cycles
// Strobe period is delay_z cycles, with a floor of MIN_STB_PERIOD
// A delay change takes effect on the next compare, not on restart
`timescale 1ns/1ps

module ll_auto_sync import lpif_pkg::*; (
  input  logic    clk_wr,
  input  logic    reset,
  input  logic    tx_online,
  input  logic    rx_online,
  input  delay_t  delay_x_value,
  input  delay_t  delay_y_value,
  input  delay_t  delay_z_value,
  input  marker_t tx_mrk_userbit,
  input  logic    tx_stb_userbit,
  lpif_sync_if.src sync
);

  sync_state_t state;
  sync_state_t state_next;
  delay_t      dly_cnt;
  delay_t      dly_cnt_next;
  delay_t      wait_target;
  logic        dly_load;
  logic        dly_done;
  logic        tx_up;

  delay_t      stb_period;
  delay_t      stb_cnt;
  delay_t      stb_cnt_next;
  logic        stb_sent;
  logic        stb_pulse;

  ////////////////////////////////////////////////////////////
  // Online sequencer

  // One shared counter, target picked by the wait state
  assign wait_target  = (state == RX_WAIT) ? delay_y_value : delay_x_value;
  assign dly_cnt_next = dly_cnt + delay_t'(1);
  // Load value is 1, so done lands on the edge ending the last cycle
  assign dly_done     = (dly_cnt_next >= wait_target);

  always_comb begin
    state_next = state;
    dly_load   = 1'b0;
    case (state)
      OFFLINE: begin
        if (tx_online) begin
          state_next = TX_WAIT;
          dly_load   = 1'b1;
        end
      end
      TX_WAIT: begin
        if (!tx_online)    state_next = OFFLINE;
        else if (dly_done) state_next = TX_UP;
      end
      TX_UP: begin
        // tx_online_delay is already high here
        if (!tx_online) begin
          state_next = OFFLINE;
        end else if (rx_online) begin
          state_next = RX_WAIT;
          dly_load   = 1'b1;
        end
      end
      RX_WAIT: begin
        if (!tx_online)      state_next = OFFLINE;
        else if (!rx_online) state_next = TX_UP;
        else if (dly_done)   state_next = LINK_UP;
      end
      LINK_UP: begin
        if (!tx_online)      state_next = OFFLINE;
        else if (!rx_online) state_next = TX_UP;
      end
      default: state_next = OFFLINE;
    endcase
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      state   <= OFFLINE;
      dly_cnt <= '0;
    end else begin
      state <= state_next;
      if (dly_load) begin
        dly_cnt <= delay_t'(1);
      end else if (state == TX_WAIT || state == RX_WAIT) begin
        dly_cnt <= dly_cnt_next;
      end
    end
  end

  // Flags decode straight from the state register
  assign tx_up                = (state == TX_UP) || (state == RX_WAIT) || (state == LINK_UP);
  assign sync.tx_online_delay = tx_up;
  assign sync.rx_online_delay = (state == LINK_UP);

  ////////////////////////////////////////////////////////////
  // Strobe generator

  assign stb_period   = (delay_z_value < delay_t'(MIN_STB_PERIOD)) ?
                        delay_t'(MIN_STB_PERIOD) : delay_z_value;
  assign stb_cnt_next = stb_cnt + delay_t'(1);

  // Counter parks at 0 while tx is held off, so first online cycle strobes
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_up) begin
      stb_cnt  <= '0;
      stb_sent <= 1'b0;
    end else begin
      if (stb_cnt_next >= stb_period) stb_cnt <= '0;
      else                            stb_cnt <= stb_cnt_next;
      if (stb_cnt == '0) stb_sent <= 1'b1;
    end
  end

  // Non-persistent mode would strobe once per online period
  assign stb_pulse        = tx_up && (stb_cnt == '0) && (PERSISTENT_STROBE || !stb_sent);
  assign sync.stb_userbit = stb_pulse | tx_stb_userbit;

  ////////////////////////////////////////////////////////////
  // Marker gating

  // Markers only leave while tx is online
  assign sync.mrk_userbit = (tx_up && (PERSISTENT_MARKER || stb_pulse)) ?
                            tx_mrk_userbit : '0;

endmodule

/* lpif_flit_map.sv */
// Registers user upstream fields into a flit and received flits out
// Gen1 mode keeps only the low 64 data bits in both directions
// Downstream fields read zero while rx_online_delay is low
`timescale 1ns/1ps

module lpif_flit_map import lpif_pkg::*; (
  input  logic                clk_wr,
  input  logic                reset,
  input  logic                m_gen2_mode,
  input  logic                rx_online_delay,
  input  flit_t               rx_flit,
  input  logic [STATE_W-1:0]  ustrm_state,
  input  logic [PROTID_W-1:0] ustrm_protid,
  input  user_data_t          ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [CRC_W-1:0]    ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,
  output flit_t               tx_flit,
  output logic [STATE_W-1:0]  dstrm_state,
  output logic [PROTID_W-1:0] dstrm_protid,
  output user_data_t          dstrm_data,
  output logic                dstrm_dvalid,
  output logic [CRC_W-1:0]    dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid
);

  user_data_t data_mask;
  flit_t      rx_masked;
  flit_t      rx_q;
  flit_t      rx_gated;

  // Gen1 keeps bits 63:0
  assign data_mask = m_gen2_mode ? '1 : user_data_t'({GEN1_DATA_W{1'b1}});

  ////////////////////////////////////////////////////////////
  // Upstream, user fields into flit order

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_flit <= '0;
    end else begin
      tx_flit <= {ustrm_state, ustrm_protid, ustrm_data & data_mask,
                  ustrm_dvalid, ustrm_crc, ustrm_crc_valid, ustrm_valid};
    end
  end

  ////////////////////////////////////////////////////////////
  // Downstream, flit onto user fields

  // Same gen1 clear on the receive data field
  always_comb begin
    rx_masked = rx_flit;
    rx_masked[FLIT_DATA_LSB +: DATA_W] = rx_flit[FLIT_DATA_LSB +: DATA_W] & data_mask;
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_q <= '0;
    end else begin
      rx_q <= rx_masked;
    end
  end

  // Link not up, nothing goes to the user
  assign rx_gated = rx_online_delay ? rx_q : '0;

  assign {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
          dstrm_crc, dstrm_crc_valid, dstrm_valid} = rx_gated;

endmodule

/* ll_phy_concat.sv */
// Packs the flit, strobe and markers into one 160-bit PHY word per clock
// Flit bits are blanked while tx is held off, userbits still go out
// No CRC check on receive, the flit is passed up as extracted
`timescale 1ns/1ps

module ll_phy_concat import lpif_pkg::*; (
  input  logic            clk_wr,
  input  logic            reset,
  lpif_sync_if.dst        sync,
  input  flit_t           tx_flit,
  input  phy_word_t       rx_phy0,
  output phy_word_t       tx_phy0,
  output flit_t           rx_flit
);

  phy_word_t tx_word;
  flit_t     rx_extract;

  ////////////////////////////////////////////////////////////
  // Transmit word

  // Unused bits 0 and 144..158 stay zero
  always_comb begin
    tx_word = '0;
    // Flit only while tx is online
    if (sync.tx_online_delay) begin
      // Low 77 flit bits, under the first marker
      tx_word[FLIT_LO_BASE +: FLIT_LO_W] = tx_flit[0 +: FLIT_LO_W];
      // Rest of the flit in the upper half
      tx_word[FLIT_HI_BASE +: FLIT_HI_W] = tx_flit[FLIT_LO_W +: FLIT_HI_W];
    end
    // Userbits, already gated by auto-sync
    tx_word[PHY_STB_BIT]  = sync.stb_userbit;
    tx_word[PHY_MRK0_BIT] = sync.mrk_userbit[0];
    tx_word[PHY_MRK1_BIT] = sync.mrk_userbit[1];
  end

  // One register stage to the PHY
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  ////////////////////////////////////////////////////////////
  // Receive word

  // Inverse of the transmit placement
  // strobe and marker bits are dropped here
  assign rx_extract = {rx_phy0[FLIT_HI_BASE +: FLIT_HI_W],
                       rx_phy0[FLIT_LO_BASE +: FLIT_LO_W]};

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      rx_flit <= '0;
    end else begin
      rx_flit <= rx_extract;
    end
  end

endmodule

/* lpif_link_slave_top.sv */
// Slave link adapter, one PHY channel, single clock clk_wr
// No logic-link FIFO and no credits; flits stream with no back-pressure
// ustrm to tx_phy0 and rx_phy0 to dstrm are 2 cycles each
`timescale 1ns/1ps

module lpif_link_slave_top import lpif_pkg::*; (
  input  logic                clk_wr,
  input  logic                reset,

  // Link control
  input  logic                tx_online,
  input  logic                rx_online,

  // PHY side
  output phy_word_t           tx_phy0,
  input  phy_word_t           rx_phy0,

  // Downstream user fields
  output logic [STATE_W-1:0]  dstrm_state,
  output logic [PROTID_W-1:0] dstrm_protid,
  output user_data_t          dstrm_data,
  output logic                dstrm_dvalid,
  output logic [CRC_W-1:0]    dstrm_crc,
  output logic                dstrm_crc_valid,
  output logic                dstrm_valid,

  // Upstream user fields
  input  logic [STATE_W-1:0]  ustrm_state,
  input  logic [PROTID_W-1:0] ustrm_protid,
  input  user_data_t          ustrm_data,
  input  logic                ustrm_dvalid,
  input  logic [CRC_W-1:0]    ustrm_crc,
  input  logic                ustrm_crc_valid,
  input  logic                ustrm_valid,

  // Debug
  output logic [31:0]         rx_downstream_debug_status,
  output logic [31:0]         tx_upstream_debug_status,

  // Config
  input  logic                m_gen2_mode,
  input  marker_t             tx_mrk_userbit,
  input  logic                tx_stb_userbit,
  input  delay_t              delay_x_value,
  input  delay_t              delay_y_value,
  input  delay_t              delay_z_value
);

  flit_t tx_flit;
  flit_t rx_flit;

  lpif_sync_if sync ();

  ////////////////////////////////////////////////////////////
  // Auto-sync
  ll_auto_sync u_auto_sync (
    .clk_wr         (clk_wr),
    .reset          (reset),
    .tx_online      (tx_online),
    .rx_online      (rx_online),
    .delay_x_value  (delay_x_value),
    .delay_y_value  (delay_y_value),
    .delay_z_value  (delay_z_value),
    .tx_mrk_userbit (tx_mrk_userbit),
    .tx_stb_userbit (tx_stb_userbit),
    .sync           (sync)
  );

  ////////////////////////////////////////////////////////////
  // User side
  lpif_flit_map u_flit_map (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .m_gen2_mode     (m_gen2_mode),
    .rx_online_delay (sync.rx_online_delay),
    .rx_flit         (rx_flit),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_flit         (tx_flit),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////////////////////////////////////////////
  // PHY side
  ll_phy_concat u_phy_concat (
    .clk_wr  (clk_wr),
    .reset   (reset),
    .sync    (sync),
    .tx_flit (tx_flit),
    .rx_phy0 (rx_phy0),
    .tx_phy0 (tx_phy0),
    .rx_flit (rx_flit)
  );

  // Both debug words: tx online at bit 19, rx online at bit 18
  assign rx_downstream_debug_status = {12'h0, sync.tx_online_delay,
                                       sync.rx_online_delay, 18'h0};
  assign tx_upstream_debug_status   = {12'h0, sync.tx_online_delay,
                                       sync.rx_online_delay, 18'h0};

endmodule

/* tb_lpif_link.sv */
// Testbench for the slave link adapter with tx_phy0 looped to rx_phy0 through one register
// Delays fixed at x=6 y=4 z=5
// tx_stb_userbit is held low throughout
// Concurrent assertions check against a cycle model kept in this module
`timescale 1ns/1ps

module tb_lpif_link;
  import lpif_pkg::*;

  localparam int DLY_X = 6;
  localparam int DLY_Y = 4;
  localparam int DLY_Z = 5;

  logic                clk_wr;
  logic                reset;
  logic                tx_online;
  logic                rx_online;
  phy_word_t           tx_phy0;
  phy_word_t           rx_phy0;
  logic [STATE_W-1:0]  ustrm_state;
  logic [PROTID_W-1:0] ustrm_protid;
  user_data_t          ustrm_data;
  logic                ustrm_dvalid;
  logic [CRC_W-1:0]    ustrm_crc;
  logic                ustrm_crc_valid;
  logic                ustrm_valid;
  logic [STATE_W-1:0]  dstrm_state;
  logic [PROTID_W-1:0] dstrm_protid;
  user_data_t          dstrm_data;
  logic                dstrm_dvalid;
  logic [CRC_W-1:0]    dstrm_crc;
  logic                dstrm_crc_valid;
  logic                dstrm_valid;
  logic [31:0]         rx_downstream_debug_status;
  logic [31:0]         tx_upstream_debug_status;
  logic                m_gen2_mode;
  marker_t             tx_mrk_userbit;
  logic                tx_stb_userbit;
  delay_t              delay_x_value;
  delay_t              delay_y_value;
  delay_t              delay_z_value;

  // Reference model state
  bit          started = 1'b0;
  bit          reset_q = 1'b0;
  int          tx_cnt = 0;
  int          rx_cnt = 0;
  int          mode_cnt = 0;
  bit          mode_q = 1'b1;
  bit          flit_on_q = 1'b0;
  bit          stb_exp = 1'b0;
  marker_t     mrk_exp = '0;
  flit_t       pipe [0:4];
  logic [31:0] rng_state = 32'd19;

  flit_t       got_dstrm;
  flit_t       got_tx_flit;
  flit_t       exp_tx_flit;

  lpif_link_slave_top dut_i (.*);

  initial begin
    clk_wr = 1'b0;
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Flit field order from the MSB down
  // Gen1 keeps only data 63:0
  function automatic flit_t pack_flit(input logic gen2);
    user_data_t d;
    d = ustrm_data;
    if (!gen2) d[127:64] = '0;
    return {ustrm_state, ustrm_protid, d, ustrm_dvalid,
            ustrm_crc, ustrm_crc_valid, ustrm_valid};
  endfunction

  // Flit bits 0..76 on PHY 2..78 and 77..140 on PHY 80..143
  function automatic flit_t phy_flit_bits(input phy_word_t w);
    return {w[143:80], w[78:2]};
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic drive_random_fields();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    r0 = next_rand();
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    r4 = next_rand();
    ustrm_data      <= {r0, r1, r2, r3};
    ustrm_state     <= r4[3:0];
    ustrm_protid    <= r4[5:4];
    ustrm_dvalid    <= r4[6];
    ustrm_crc       <= r4[10:7];
    ustrm_crc_valid <= r4[11];
    ustrm_valid     <= r4[12];
    tx_mrk_userbit  <= r4[14:13];
  endtask

  // One fresh random field set per rising edge
  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge clk_wr);
      drive_random_fields();
    end
  endtask

  task automatic wait_debug_level(input int idx, input logic level, input int limit,
                                  input string what);
    int n;
    bit seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < limit) begin
      run_cycles(1);
      seen = (rx_downstream_debug_status[idx] == level);
      n++;
    end
    if (!seen) fail_now($sformatf("timeout waiting for %s", what));
  endtask

  ////////////////////////////////////////////////////////////
  // Loopback and reference model

  always @(posedge clk_wr) begin
    rx_phy0 <= reset ? '0 : tx_phy0;
  end

  always @(posedge clk_wr) begin
    started <= 1'b1;
    reset_q <= reset;
    mode_q  <= m_gen2_mode;
    if (reset) begin
      tx_cnt    <= 0;
      rx_cnt    <= 0;
      mode_cnt  <= 0;
      flit_on_q <= 1'b0;
      stb_exp   <= 1'b0;
      mrk_exp   <= '0;
      for (int i = 0; i < 5; i++) pipe[i] <= '0;
    end else begin
      // Cycles with tx_online seen high and with rx_online on top of tx up
      tx_cnt   <= tx_online ? tx_cnt + 1 : 0;
      rx_cnt   <= (tx_online && rx_online && tx_cnt >= DLY_X) ? rx_cnt + 1 : 0;
      mode_cnt <= (m_gen2_mode == mode_q) ? mode_cnt + 1 : 0;
      // Word registered at this edge
      flit_on_q <= (tx_cnt >= DLY_X);
      stb_exp   <= tx_stb_userbit ||
                   (tx_cnt >= DLY_X && ((tx_cnt - DLY_X) % DLY_Z) == 0);
      mrk_exp   <= (tx_cnt >= DLY_X) ? tx_mrk_userbit : '0;
      pipe[0]   <= pack_flit(m_gen2_mode);
      for (int i = 1; i < 5; i++) pipe[i] <= pipe[i-1];
    end
  end

  assign got_dstrm   = {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                        dstrm_crc, dstrm_crc_valid, dstrm_valid};
  assign got_tx_flit = phy_flit_bits(tx_phy0);
  assign exp_tx_flit = flit_on_q ? pipe[1] : '0;

  ////////////////////////////////////////////////////////////
  // Checks

  a_reset_phy: assert property (@(posedge clk_wr) !reset_q || tx_phy0 == '0)
    else fail_now($sformatf("ERR tx_phy0 got %h exp 0", $sampled(tx_phy0)));
  a_reset_dstrm: assert property (@(posedge clk_wr) !reset_q || got_dstrm == '0)
    else fail_now($sformatf("ERR dstrm fields got %h exp 0", $sampled(got_dstrm)));
  a_reset_dbg: assert property (@(posedge clk_wr)
      !reset_q || (rx_downstream_debug_status == '0 && tx_upstream_debug_status == '0))
    else fail_now($sformatf("ERR rx/tx debug_status got %h %h exp 0",
                            $sampled(rx_downstream_debug_status),
                            $sampled(tx_upstream_debug_status)));

  // Debug words agree and use only bits 19 and 18
  a_dbg_equal: assert property (@(posedge clk_wr) !started ||
      (rx_downstream_debug_status == tx_upstream_debug_status &&
       (rx_downstream_debug_status & ~32'h000C_0000) == '0))
    else fail_now($sformatf("ERR tx_upstream_debug_status got %h exp %h",
                            $sampled(tx_upstream_debug_status),
                            $sampled(rx_downstream_debug_status)));
  a_tx_up: assert property (@(posedge clk_wr) !started ||
      rx_downstream_debug_status[19] == (tx_cnt >= DLY_X))
    else fail_now($sformatf("ERR rx_downstream_debug_status[19] got %h exp %h",
                            $sampled(rx_downstream_debug_status[19]),
                            $sampled(tx_cnt >= DLY_X)));
  a_rx_up: assert property (@(posedge clk_wr) !started ||
      rx_downstream_debug_status[18] == (rx_cnt >= DLY_Y))
    else fail_now($sformatf("ERR rx_downstream_debug_status[18] got %h exp %h",
                            $sampled(rx_downstream_debug_status[18]),
                            $sampled(rx_cnt >= DLY_Y)));

  // PHY word layout
  a_unused: assert property (@(posedge clk_wr) !started ||
      (tx_phy0[0] == 1'b0 && tx_phy0[158:144] == '0))
    else fail_now($sformatf("ERR tx_phy0 unused bits got %h exp 0", $sampled(tx_phy0)));
  a_strobe: assert property (@(posedge clk_wr) !started || tx_phy0[PHY_STB_BIT] == stb_exp)
    else fail_now($sformatf("ERR tx_phy0[1] got %h exp %h",
                            $sampled(tx_phy0[PHY_STB_BIT]), $sampled(stb_exp)));
  a_marker: assert property (@(posedge clk_wr) !started ||
      {tx_phy0[PHY_MRK1_BIT], tx_phy0[PHY_MRK0_BIT]} == mrk_exp)
    else fail_now($sformatf("ERR tx_phy0 markers got %h exp %h",
                            $sampled({tx_phy0[PHY_MRK1_BIT], tx_phy0[PHY_MRK0_BIT]}),
                            $sampled(mrk_exp)));
  // Blanked while tx is held off or else the flit from two edges back
  a_tx_flit: assert property (@(posedge clk_wr) !started || got_tx_flit == exp_tx_flit)
    else fail_now($sformatf("ERR tx_phy0 flit got %h exp %h",
                            $sampled(got_tx_flit), $sampled(exp_tx_flit)));

  // Downstream side
  a_dstrm_off: assert property (@(posedge clk_wr) !started || rx_cnt >= DLY_Y ||
      got_dstrm == '0)
    else fail_now($sformatf("ERR dstrm fields got %h exp 0", $sampled(got_dstrm)));
  a_loopback: assert property (@(posedge clk_wr) !started || rx_cnt < DLY_Y + 2 ||
      mode_cnt < 6 || got_dstrm == pipe[4])
    else fail_now($sformatf("ERR dstrm fields got %h exp %h",
                            $sampled(got_dstrm), $sampled(pipe[4])));
  a_gen1_upper: assert property (@(posedge clk_wr) !started || mode_q || mode_cnt < 6 ||
      dstrm_data[127:64] == '0)
    else fail_now($sformatf("ERR dstrm_data got %h exp upper half 0",
                            $sampled(dstrm_data)));

  ////////////////////////////////////////////////////////////
  // Stimulus

  initial begin
    reset           = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    rx_phy0         = '0;
    ustrm_state     = '0;
    ustrm_protid    = '0;
    ustrm_data      = '0;
    ustrm_dvalid    = 1'b0;
    ustrm_crc       = '0;
    ustrm_crc_valid = 1'b0;
    ustrm_valid     = 1'b0;
    m_gen2_mode     = 1'b1;
    tx_mrk_userbit  = '0;
    tx_stb_userbit  = 1'b0;
    delay_x_value   = delay_t'(DLY_X);
    delay_y_value   = delay_t'(DLY_Y);
    delay_z_value   = delay_t'(DLY_Z);
    repeat (3) @(posedge clk_wr);
    reset <= 1'b0;
    // Offline traffic keeps the flit blank
    run_cycles(8);
    tx_online <= 1'b1;
    wait_debug_level(19, 1'b1, 40, "tx online delay");
    run_cycles(5);
    rx_online <= 1'b1;
    wait_debug_level(18, 1'b1, 40, "rx online delay");
    // Gen2 then gen1 streaming
    run_cycles(60);
    m_gen2_mode <= 1'b0;
    run_cycles(60);
    m_gen2_mode <= 1'b1;
    run_cycles(10);
    // rx drop and return
    rx_online <= 1'b0;
    wait_debug_level(18, 1'b0, 20, "rx online delay low");
    run_cycles(12);
    rx_online <= 1'b1;
    wait_debug_level(18, 1'b1, 40, "rx online delay after rx return");
    run_cycles(20);
    // tx drop takes the whole link down
    tx_online <= 1'b0;
    wait_debug_level(19, 1'b0, 20, "tx online delay low");
    run_cycles(15);
    tx_online <= 1'b1;
    wait_debug_level(18, 1'b1, 60, "link up after tx return");
    run_cycles(30);
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* all.f */
lpif_pkg.sv
lpif_sync_if.sv
ll_auto_sync.sv
lpif_flit_map.sv
ll_phy_concat.sv
lpif_link_slave_top.sv
tb_lpif_link.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator and run the link adapter testbench
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_lpif_link

# The simulation exits nonzero on a fatal error, the log decides
./obj_dir/Vtb_lpif_link > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
